/* ooo_core.f */
hw/ooo_pkg.sv
hw/rename_regfile.sv
hw/reorder_buffer.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/ooo_core.sv
verification/ooo_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ooo_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f ooo_core.f --top-module ooo_core_tb \
  --Mdir "$BUILD_DIR" -o ooo_core_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/ooo_core_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* verification/ooo_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 3;
  localparam int N_SEED       = 16;  // SUBS then an ADC chain through r1..r15
  localparam int N_INDEP      = 7;
  localparam int N_RAND       = 200;
  localparam int N_BURST      = 24;  // Longer than the ROB
  localparam int N_TOTAL      = N_SEED + N_INDEP + N_RAND + N_BURST;
  localparam int WATCHDOG_NS  = (N_TOTAL * 20 + RESET_CYCLES) * CLK_PERIOD;
  localparam int ENTRY_W      = 1 + NZCV_W + GPR_IDX_W + GPR_W;
  localparam logic [OP_W-1:0] ALL_OPS [7] = '{OP_MOV, OP_ADD, OP_SUB, OP_AND,
                                             OP_ORR, OP_EOR, OP_ADC};

  logic                 in_clk;
  logic                 in_rst_n;
  logic                 issue_valid;
  logic [OP_W-1:0]      issue_op;
  logic [GPR_IDX_W-1:0] issue_dst;
  logic [GPR_IDX_W-1:0] issue_src1;
  logic [GPR_IDX_W-1:0] issue_src2;
  logic                 issue_set_nzcv;
  logic                 issue_ready;
  logic                 commit_valid;
  logic [GPR_IDX_W-1:0] commit_dst;
  logic [GPR_W-1:0]     commit_value;
  logic                 commit_set_nzcv;
  logic [NZCV_W-1:0]    commit_nzcv;

  logic [15:0]          lfsr_state;
  logic [GPR_W-1:0]     model_regs [GPR_COUNT];
  logic [NZCV_W-1:0]    model_flags;
  logic [ENTRY_W-1:0]   expect_q [$];  // {set_nzcv, nzcv, dst, value}
  logic [GPR_IDX_W-1:0] recent [4];    // Last destinations for dense dependencies
  logic [1:0]           recent_ptr = '0;
  logic                 issued_any = 1'b0;
  logic                 in_burst = 1'b0;
  int                   error_count = 0;
  int                   accepted = 0;
  int                   committed = 0;
  int                   stall_count = 0;

  ooo_core UUT (.*);

  always #(CLK_PERIOD / 2) in_clk = !in_clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int nbits, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Reference result and flags as {value, nzcv}
  function automatic logic [GPR_W+NZCV_W-1:0] model_exec(input logic [OP_W-1:0] op,
      input logic [GPR_W-1:0] a, input logic [GPR_W-1:0] b,
      input logic [NZCV_W-1:0] fin, input logic set);
    logic [GPR_W:0]    wide;
    logic [GPR_W-1:0]  res;
    logic [NZCV_W-1:0] f;
    logic              c;
    logic              v;
    c = 1'b0;
    v = 1'b0;
    case (op)
      OP_MOV: res = b;
      OP_AND: res = a & b;
      OP_ORR: res = a | b;
      OP_EOR: res = a ^ b;
      OP_SUB: begin
        res = a - b;
        c   = a >= b;  // Set when there is no borrow
        v   = (a[GPR_W-1] != b[GPR_W-1]) && (res[GPR_W-1] != a[GPR_W-1]);
      end
      OP_ADD, OP_ADC: begin
        wide = {1'b0, a} + {1'b0, b} +
               {{GPR_W{1'b0}}, (op == OP_ADC) && fin[FLAG_C]};
        res  = wide[GPR_W-1:0];
        c    = wide[GPR_W];
        v    = (a[GPR_W-1] == b[GPR_W-1]) && (res[GPR_W-1] != a[GPR_W-1]);
      end
      default: res = '0;
    endcase
    f = fin;  // Untouched unless the op sets flags
    if (set) begin
      f[FLAG_N] = res[GPR_W-1];
      f[FLAG_Z] = res == '0;
      f[FLAG_C] = c;
      f[FLAG_V] = v;
    end
    model_exec = {res, f};
  endfunction

  task automatic report_mismatch(input string name, input logic [GPR_W-1:0] got,
                                 input logic [GPR_W-1:0] want);
    $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, want);
    error_count++;
  endtask

  task automatic print_summary();
    $display("Summary: %0d accepted, %0d committed, %0d stalls in burst, %0d errors",
             accepted, committed, stall_count, error_count);
  endtask

  // Sampled on the falling edge where inputs and outputs are settled
  always @(negedge in_clk) begin : monitor
    logic [ENTRY_W-1:0]        head;
    logic [GPR_W+NZCV_W-1:0]   r;
    if (!in_rst_n) begin
      for (int i = 0; i < GPR_COUNT; i++)
        model_regs[i] = '0;
      model_flags = '0;
    end
    if (!in_rst_n || !issued_any) begin
      assert (!commit_valid) else begin
        $display("commit_valid went high at %0t ns before any instruction", $time);
        error_count++;
      end
      assert (issue_ready) else begin
        $display("issue_ready was low at %0t ns while the core was idle", $time);
        error_count++;
      end
    end
    if (in_rst_n && commit_valid) begin
      committed++;
      if (expect_q.size() == 0) begin
        $display("Commit at %0t ns with no instruction outstanding", $time);
        error_count++;
      end else begin
        head = expect_q.pop_front();
        assert (commit_dst == head[GPR_W +: GPR_IDX_W]) else
          report_mismatch("commit_dst", GPR_W'(commit_dst), GPR_W'(head[GPR_W +: GPR_IDX_W]));
        assert (commit_value == head[GPR_W-1:0]) else
          report_mismatch("commit_value", commit_value, head[GPR_W-1:0]);
        assert (commit_set_nzcv == head[ENTRY_W-1]) else
          report_mismatch("commit_set_nzcv", GPR_W'(commit_set_nzcv), GPR_W'(head[ENTRY_W-1]));
        assert (!head[ENTRY_W-1] || commit_nzcv == head[GPR_W+GPR_IDX_W +: NZCV_W]) else
          report_mismatch("commit_nzcv", GPR_W'(commit_nzcv),
                          GPR_W'(head[GPR_W+GPR_IDX_W +: NZCV_W]));
      end
    end
    if (in_rst_n && issue_valid && issue_ready) begin
      r = model_exec(issue_op, model_regs[issue_src1], model_regs[issue_src2],
                     model_flags, issue_set_nzcv);
      model_regs[issue_dst] = r[GPR_W+NZCV_W-1:NZCV_W];
      model_flags           = r[NZCV_W-1:0];
      expect_q.push_back({issue_set_nzcv, r[NZCV_W-1:0], issue_dst, r[GPR_W+NZCV_W-1:NZCV_W]});
      accepted++;
      issued_any = 1'b1;
    end
    if (in_rst_n && in_burst && issue_valid && !issue_ready)
      stall_count++;
  end

  // Holds the instruction until the core takes it
  task automatic send(input logic [OP_W-1:0] op, input logic [GPR_IDX_W-1:0] dst,
                      input logic [GPR_IDX_W-1:0] s1, input logic [GPR_IDX_W-1:0] s2,
                      input logic set);
    issue_valid    = 1'b1;
    issue_op       = op;
    issue_dst      = dst;
    issue_src1     = s1;
    issue_src2     = s2;
    issue_set_nzcv = set;
    @(negedge in_clk);
    while (!issue_ready)
      @(negedge in_clk);
    @(posedge in_clk);
    #1;
    issue_valid        = 1'b0;
    recent[recent_ptr] = dst;
    recent_ptr         = recent_ptr + 2'd1;
  endtask

  task automatic pick_source(output logic [GPR_IDX_W-1:0] src);
    logic [31:0] v;
    draw(2, v);
    if (v[1:0] != 2'd0) begin
      draw(2, v);
      src = recent[v[1:0]];  // Three times in four a recent destination
    end else begin
      draw(GPR_IDX_W, v);
      src = v[GPR_IDX_W-1:0];
    end
  endtask

  task automatic send_random(input logic gapped);
    logic [31:0]          v;
    logic [OP_W-1:0]      op;
    logic [GPR_IDX_W-1:0] dst;
    logic [GPR_IDX_W-1:0] s1;
    logic [GPR_IDX_W-1:0] s2;
    logic                 set;
    draw(OP_W, v);
    op = (v[OP_W-1:0] == 3'd7) ? OP_ADC : v[OP_W-1:0];
    draw(GPR_IDX_W, v);
    dst = v[GPR_IDX_W-1:0];
    pick_source(s1);
    pick_source(s2);
    draw(1, v);
    set = v[0];
    send(op, dst, s1, s2, set);
    if (gapped) begin
      draw(2, v);
      repeat (int'(v[1:0])) begin
        @(posedge in_clk);
        #1;
      end
    end
  endtask

  initial begin
    in_clk         = 1'b0;
    in_rst_n       = 1'b0;
    issue_valid    = 1'b0;
    issue_op       = OP_MOV;
    issue_dst      = '0;
    issue_src1     = '0;
    issue_src2     = '0;
    issue_set_nzcv = 1'b0;
    lfsr_state     = 16'd55726;
    for (int i = 0; i < 4; i++)
      recent[i] = GPR_IDX_W'(i);
    repeat (RESET_CYCLES) @(posedge in_clk);
    #1 in_rst_n = 1'b1;
    repeat (3) @(posedge in_clk);  // Idle with no commits yet
    #1;

    // SUBS sets C and each ADC then doubles the previous register plus one
    send(OP_SUB, 4'd0, 4'd0, 4'd0, 1'b1);
    for (int k = 1; k < GPR_COUNT; k++)
      send(OP_ADC, GPR_IDX_W'(k), GPR_IDX_W'(k - 1), GPR_IDX_W'(k - 1), 1'b0);

    for (int i = 0; i < N_INDEP; i++)
      send(ALL_OPS[i], GPR_IDX_W'(8 + i), GPR_IDX_W'(1 + i), GPR_IDX_W'(7 - i), i[0]);

    for (int i = 0; i < N_RAND; i++)
      send_random(1'b1);

    in_burst = 1'b1;
    for (int i = 0; i < N_BURST; i++)
      send_random(1'b0);
    in_burst = 1'b0;

    while (expect_q.size() != 0)
      @(negedge in_clk);
    repeat (5) @(posedge in_clk);  // Any extra commit shows up here

    assert (committed == accepted) else begin
      $display("%0d commits seen for %0d accepted instructions", committed, accepted);
      error_count++;
    end
    assert (stall_count > 0) else begin
      $display("issue_ready never went low during the burst");
      error_count++;
    end

    print_summary();
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish, %0d of %0d accepted instructions committed",
             committed, accepted);
    print_summary();
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
  parameter int ROB_DEPTH = 8,
  parameter int RS_DEPTH = 4
) (
  input  logic                           in_clk,
  input  logic                           in_rst_n,
  input  logic                           issue_valid,
  input  logic [ooo_pkg::OP_W-1:0]       issue_op,
  input  logic [ooo_pkg::GPR_IDX_W-1:0]  issue_dst,
  input  logic [ooo_pkg::GPR_IDX_W-1:0]  issue_src1,
  input  logic [ooo_pkg::GPR_IDX_W-1:0]  issue_src2,
  input  logic                           issue_set_nzcv,
  output logic                           issue_ready,
  output logic                           commit_valid,
  output logic [ooo_pkg::GPR_IDX_W-1:0]  commit_dst,
  output logic [ooo_pkg::GPR_W-1:0]      commit_value,
  output logic                           commit_set_nzcv,
  output logic [ooo_pkg::NZCV_W-1:0]     commit_nzcv
);
  import ooo_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH);

  // Rename to ROB
  logic                 rob_full;
  logic                 rs_full;
  logic [TAG_W-1:0]     alloc_tag;
  logic                 alloc_valid;
  logic [OP_W-1:0]      alloc_op;
  logic [GPR_IDX_W-1:0] alloc_dst;
  logic                 alloc_set_nzcv;
  logic                 src1_ready;
  logic [GPR_W-1:0]     src1_value;
  logic [TAG_W-1:0]     src1_tag;
  logic                 src2_ready;
  logic [GPR_W-1:0]     src2_value;
  logic [TAG_W-1:0]     src2_tag;
  logic                 nzcv_ready;
  logic [NZCV_W-1:0]    nzcv_value;
  logic [TAG_W-1:0]     nzcv_tag;
  logic [TAG_W-1:0]     commit_tag;

  // ROB to RS, including broadcast
  logic                 rs_insert_valid;
  logic [OP_W-1:0]      rs_op;
  logic                 rs_set_nzcv;
  logic [TAG_W-1:0]     rs_dst_tag;
  logic                 rs_a_ready;
  logic [GPR_W-1:0]     rs_a_value;
  logic [TAG_W-1:0]     rs_a_tag;
  logic                 rs_b_ready;
  logic [GPR_W-1:0]     rs_b_value;
  logic [TAG_W-1:0]     rs_b_tag;
  logic                 rs_f_ready;
  logic [NZCV_W-1:0]    rs_f_value;
  logic [TAG_W-1:0]     rs_f_tag;
  logic                 bc_valid;
  logic [TAG_W-1:0]     bc_tag;
  logic [GPR_W-1:0]     bc_value;
  logic                 bc_set_nzcv;
  logic [NZCV_W-1:0]    bc_nzcv;

  // RS to ALU to ROB
  logic                 exec_valid;
  logic [OP_W-1:0]      exec_op;
  logic [GPR_W-1:0]     exec_a;
  logic [GPR_W-1:0]     exec_b;
  logic [NZCV_W-1:0]    exec_nzcv;
  logic                 exec_set_nzcv;
  logic [TAG_W-1:0]     exec_tag;
  logic                 fu_done;
  logic [TAG_W-1:0]     fu_tag;
  logic [GPR_W-1:0]     fu_value;
  logic                 fu_set_nzcv;
  logic [NZCV_W-1:0]    fu_nzcv;

  // Port names match the nets above one to one
  rename_regfile #(.ROB_DEPTH(ROB_DEPTH)) u_regfile (.*);

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (.*);

  reservation_station #(
    .ROB_DEPTH(ROB_DEPTH),
    .RS_DEPTH (RS_DEPTH)
  ) u_rs (.*);

  alu_unit #(.ROB_DEPTH(ROB_DEPTH)) u_alu (.*);

endmodule

`default_nettype wire

/* hw/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic                        in_clk,
  input  logic                        in_rst_n,
  input  logic                        exec_valid,
  input  logic [ooo_pkg::OP_W-1:0]    exec_op,
  input  logic [ooo_pkg::GPR_W-1:0]   exec_a,
  input  logic [ooo_pkg::GPR_W-1:0]   exec_b,
  input  logic [ooo_pkg::NZCV_W-1:0]  exec_nzcv,
  input  logic                        exec_set_nzcv,
  input  logic [TAG_W-1:0]            exec_tag,
  output logic                        fu_done,
  output logic [TAG_W-1:0]            fu_tag,
  output logic [ooo_pkg::GPR_W-1:0]   fu_value,
  output logic                        fu_set_nzcv,
  output logic [ooo_pkg::NZCV_W-1:0]  fu_nzcv
);
  import ooo_pkg::*;

  logic              arith;
  logic [GPR_W-1:0]  opb;    // Inverted for subtraction
  logic              cin;
  logic [GPR_W:0]    sum;
  logic [GPR_W-1:0]  res;
  logic [NZCV_W-1:0] flags;

  always_comb begin
    arith = exec_op == OP_ADD || exec_op == OP_SUB || exec_op == OP_ADC;
    opb   = (exec_op == OP_SUB) ? ~exec_b : exec_b;
    case (exec_op)
      OP_SUB:  cin = 1'b1;
      OP_ADC:  cin = exec_nzcv[FLAG_C];
      default: cin = 1'b0;
    endcase
    sum = {1'b0, exec_a} + {1'b0, opb} + {{GPR_W{1'b0}}, cin};
    case (exec_op)
      OP_MOV:  res = exec_b;
      OP_AND:  res = exec_a & exec_b;
      OP_ORR:  res = exec_a | exec_b;
      OP_EOR:  res = exec_a ^ exec_b;
      default: res = sum[GPR_W-1:0];
    endcase
    flags         = '0;  // C and V stay clear for logic ops
    flags[FLAG_N] = res[GPR_W-1];
    flags[FLAG_Z] = res == '0;
    if (arith) begin
      flags[FLAG_C] = sum[GPR_W];  // Carry out, no borrow on SUB
      flags[FLAG_V] = exec_a[GPR_W-1] == opb[GPR_W-1] && res[GPR_W-1] != exec_a[GPR_W-1];
    end
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n)
      fu_done <= 1'b0;
    else
      fu_done <= exec_valid;
  end

  always_ff @(posedge in_clk) begin
    fu_tag      <= exec_tag;
    fu_value    <= res;
    fu_set_nzcv <= exec_set_nzcv;
    fu_nzcv     <= exec_set_nzcv ? flags : exec_nzcv;
  end

endmodule

`default_nettype wire

/* hw/reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
  parameter int ROB_DEPTH = 8,
  parameter int RS_DEPTH = 4,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic                        in_clk,
  input  logic                        in_rst_n,
  input  logic                        rs_insert_valid,
  input  logic [ooo_pkg::OP_W-1:0]    rs_op,
  input  logic                        rs_set_nzcv,
  input  logic [TAG_W-1:0]            rs_dst_tag,
  input  logic                        rs_a_ready,
  input  logic [ooo_pkg::GPR_W-1:0]   rs_a_value,
  input  logic [TAG_W-1:0]            rs_a_tag,
  input  logic                        rs_b_ready,
  input  logic [ooo_pkg::GPR_W-1:0]   rs_b_value,
  input  logic [TAG_W-1:0]            rs_b_tag,
  input  logic                        rs_f_ready,
  input  logic [ooo_pkg::NZCV_W-1:0]  rs_f_value,
  input  logic [TAG_W-1:0]            rs_f_tag,
  input  logic                        bc_valid,
  input  logic [TAG_W-1:0]            bc_tag,
  input  logic [ooo_pkg::GPR_W-1:0]   bc_value,
  input  logic                        bc_set_nzcv,
  input  logic [ooo_pkg::NZCV_W-1:0]  bc_nzcv,
  output logic                        rs_full,
  output logic                        exec_valid,
  output logic [ooo_pkg::OP_W-1:0]    exec_op,
  output logic [ooo_pkg::GPR_W-1:0]   exec_a,
  output logic [ooo_pkg::GPR_W-1:0]   exec_b,
  output logic [ooo_pkg::NZCV_W-1:0]  exec_nzcv,
  output logic                        exec_set_nzcv,
  output logic [TAG_W-1:0]            exec_tag
);
  import ooo_pkg::*;

  localparam int IDX_W = $clog2(RS_DEPTH);

  logic [RS_DEPTH-1:0] ent_valid;
  logic [IDX_W-1:0]    ent_rank [RS_DEPTH];  // Number of older entries
  logic [OP_W-1:0]     ent_op   [RS_DEPTH];
  logic [RS_DEPTH-1:0] ent_set_nzcv;
  logic [TAG_W-1:0]    ent_tag  [RS_DEPTH];
  logic [RS_DEPTH-1:0] a_rdy;
  logic [RS_DEPTH-1:0] b_rdy;
  logic [RS_DEPTH-1:0] f_rdy;
  logic [GPR_W-1:0]    a_val    [RS_DEPTH];
  logic [GPR_W-1:0]    b_val    [RS_DEPTH];
  logic [NZCV_W-1:0]   f_val    [RS_DEPTH];
  logic [TAG_W-1:0]    a_tag    [RS_DEPTH];
  logic [TAG_W-1:0]    b_tag    [RS_DEPTH];
  logic [TAG_W-1:0]    f_tag    [RS_DEPTH];

  logic [IDX_W:0]      used;
  logic [IDX_W-1:0]    free_idx;
  logic                sel_hit;
  logic [IDX_W-1:0]    sel_idx;
  logic [IDX_W-1:0]    sel_rank;
  logic                bypass;   // Incoming entry goes straight to the ALU
  logic                store;
  logic                bc_a;
  logic                bc_b;
  logic                bc_f;

  // Occupancy, lowest free slot and oldest ready entry
  always_comb begin
    used     = '0;
    free_idx = '0;
    sel_hit  = 1'b0;
    sel_idx  = '0;
    sel_rank = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (ent_valid[i])
        used = used + 1'b1;
      else
        free_idx = IDX_W'(i);
      if (ent_valid[i] && a_rdy[i] && b_rdy[i] && f_rdy[i] &&
          (!sel_hit || ent_rank[i] < sel_rank)) begin
        sel_hit  = 1'b1;
        sel_idx  = IDX_W'(i);
        sel_rank = ent_rank[i];
      end
    end
  end

  assign rs_full = used >= (IDX_W + 1)'(RS_DEPTH - 1);  // Room kept for one pending insert
  assign bypass  = rs_insert_valid && rs_a_ready && rs_b_ready && rs_f_ready && !sel_hit;
  assign store   = rs_insert_valid && !bypass;
  assign bc_a    = bc_valid && bc_tag == rs_a_tag;
  assign bc_b    = bc_valid && bc_tag == rs_b_tag;
  assign bc_f    = bc_valid && bc_set_nzcv && bc_tag == rs_f_tag;

  assign exec_valid    = sel_hit || bypass;
  assign exec_op       = sel_hit ? ent_op[sel_idx] : rs_op;
  assign exec_a        = sel_hit ? a_val[sel_idx] : rs_a_value;
  assign exec_b        = sel_hit ? b_val[sel_idx] : rs_b_value;
  assign exec_nzcv     = sel_hit ? f_val[sel_idx] : rs_f_value;
  assign exec_set_nzcv = sel_hit ? ent_set_nzcv[sel_idx] : rs_set_nzcv;
  assign exec_tag      = sel_hit ? ent_tag[sel_idx] : rs_dst_tag;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      ent_valid <= '0;
      for (int i = 0; i < RS_DEPTH; i++)
        ent_rank[i] <= '0;
    end else begin
      if (sel_hit) begin
        ent_valid[sel_idx] <= 1'b0;
        for (int i = 0; i < RS_DEPTH; i++)
          if (ent_valid[i] && ent_rank[i] > sel_rank)
            ent_rank[i] <= ent_rank[i] - 1'b1;
      end
      if (store) begin
        ent_valid[free_idx] <= 1'b1;
        ent_rank[free_idx]  <= IDX_W'(used - (IDX_W + 1)'(sel_hit));  // Youngest
      end
    end
  end

  always_ff @(posedge in_clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (bc_valid && !a_rdy[i] && a_tag[i] == bc_tag) begin
        a_rdy[i] <= 1'b1;
        a_val[i] <= bc_value;
      end
      if (bc_valid && !b_rdy[i] && b_tag[i] == bc_tag) begin
        b_rdy[i] <= 1'b1;
        b_val[i] <= bc_value;
      end
      if (bc_valid && bc_set_nzcv && !f_rdy[i] && f_tag[i] == bc_tag) begin
        f_rdy[i] <= 1'b1;
        f_val[i] <= bc_nzcv;
      end
    end
    if (store) begin
      ent_op[free_idx]       <= rs_op;
      ent_set_nzcv[free_idx] <= rs_set_nzcv;
      ent_tag[free_idx]      <= rs_dst_tag;
      a_rdy[free_idx]        <= rs_a_ready || bc_a;
      a_val[free_idx]        <= rs_a_ready ? rs_a_value : bc_value;
      a_tag[free_idx]        <= rs_a_tag;
      b_rdy[free_idx]        <= rs_b_ready || bc_b;
      b_val[free_idx]        <= rs_b_ready ? rs_b_value : bc_value;
      b_tag[free_idx]        <= rs_b_tag;
      f_rdy[free_idx]        <= rs_f_ready || bc_f;
      f_val[free_idx]        <= rs_f_ready ? rs_f_value : bc_nzcv;
      f_tag[free_idx]        <= rs_f_tag;
    end
  end

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic                           in_clk,
  input  logic                           in_rst_n,
  input  logic                           alloc_valid,
  input  logic [ooo_pkg::OP_W-1:0]       alloc_op,
  input  logic [ooo_pkg::GPR_IDX_W-1:0]  alloc_dst,
  input  logic                           alloc_set_nzcv,
  input  logic                           src1_ready,
  input  logic [ooo_pkg::GPR_W-1:0]      src1_value,
  input  logic [TAG_W-1:0]               src1_tag,
  input  logic                           src2_ready,
  input  logic [ooo_pkg::GPR_W-1:0]      src2_value,
  input  logic [TAG_W-1:0]               src2_tag,
  input  logic                           nzcv_ready,
  input  logic [ooo_pkg::NZCV_W-1:0]     nzcv_value,
  input  logic [TAG_W-1:0]               nzcv_tag,
  input  logic                           fu_done,
  input  logic [TAG_W-1:0]               fu_tag,
  input  logic [ooo_pkg::GPR_W-1:0]      fu_value,
  input  logic                           fu_set_nzcv,
  input  logic [ooo_pkg::NZCV_W-1:0]     fu_nzcv,
  output logic [TAG_W-1:0]               alloc_tag,
  output logic                           rob_full,
  output logic                           rs_insert_valid,
  output logic [ooo_pkg::OP_W-1:0]       rs_op,
  output logic                           rs_set_nzcv,
  output logic [TAG_W-1:0]               rs_dst_tag,
  output logic                           rs_a_ready,
  output logic [ooo_pkg::GPR_W-1:0]      rs_a_value,
  output logic [TAG_W-1:0]               rs_a_tag,
  output logic                           rs_b_ready,
  output logic [ooo_pkg::GPR_W-1:0]      rs_b_value,
  output logic [TAG_W-1:0]               rs_b_tag,
  output logic                           rs_f_ready,
  output logic [ooo_pkg::NZCV_W-1:0]     rs_f_value,
  output logic [TAG_W-1:0]               rs_f_tag,
  output logic                           bc_valid,
  output logic [TAG_W-1:0]               bc_tag,
  output logic [ooo_pkg::GPR_W-1:0]      bc_value,
  output logic                           bc_set_nzcv,
  output logic [ooo_pkg::NZCV_W-1:0]     bc_nzcv,
  output logic                           commit_valid,
  output logic [TAG_W-1:0]               commit_tag,
  output logic [ooo_pkg::GPR_IDX_W-1:0]  commit_dst,
  output logic [ooo_pkg::GPR_W-1:0]      commit_value,
  output logic                           commit_set_nzcv,
  output logic [ooo_pkg::NZCV_W-1:0]     commit_nzcv
);
  import ooo_pkg::*;

  logic [GPR_IDX_W-1:0] ent_dst   [ROB_DEPTH];
  logic [GPR_W-1:0]     ent_value [ROB_DEPTH];
  logic [NZCV_W-1:0]    ent_nzcv  [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] ent_set_nzcv;
  logic [ROB_DEPTH-1:0] ent_done;  // Result written back by the ALU
  logic [TAG_W-1:0]     head;
  logic [TAG_W-1:0]     tail;
  logic [TAG_W:0]       count;

  // Allocation held one cycle, then resolved against the entries
  logic                 q_valid;
  logic [OP_W-1:0]      q_op;
  logic                 q_set_nzcv;
  logic [TAG_W-1:0]     q_tag;
  logic                 q_a_ready;
  logic [GPR_W-1:0]     q_a_value;
  logic [TAG_W-1:0]     q_a_tag;
  logic                 q_b_ready;
  logic [GPR_W-1:0]     q_b_value;
  logic [TAG_W-1:0]     q_b_tag;
  logic                 q_f_ready;
  logic [NZCV_W-1:0]    q_f_value;
  logic [TAG_W-1:0]     q_f_tag;

  assign alloc_tag = tail;
  assign rob_full  = count == (TAG_W + 1)'(ROB_DEPTH);

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      ent_done <= '0;
      q_valid  <= 1'b0;
      bc_valid <= 1'b0;
    end else begin
      q_valid  <= alloc_valid;
      bc_valid <= fu_done;
      if (fu_done)
        ent_done[fu_tag] <= 1'b1;
      if (commit_valid) begin
        ent_done[head] <= 1'b0;
        head           <= head + 1'b1;  // Wraps, depth is a power of two
      end
      if (alloc_valid) begin
        ent_done[tail] <= 1'b0;
        tail           <= tail + 1'b1;
      end
      count <= count + (TAG_W + 1)'(alloc_valid) - (TAG_W + 1)'(commit_valid);
    end
  end

  always_ff @(posedge in_clk) begin
    if (alloc_valid) begin
      ent_dst[tail]      <= alloc_dst;
      ent_set_nzcv[tail] <= alloc_set_nzcv;
    end
    if (fu_done) begin
      ent_value[fu_tag] <= fu_value;
      ent_nzcv[fu_tag]  <= fu_nzcv;
    end
    q_op        <= alloc_op;
    q_set_nzcv  <= alloc_set_nzcv;
    q_tag       <= tail;
    q_a_ready   <= src1_ready;
    q_a_value   <= src1_value;
    q_a_tag     <= src1_tag;
    q_b_ready   <= src2_ready;
    q_b_value   <= src2_value;
    q_b_tag     <= src2_tag;
    q_f_ready   <= nzcv_ready;
    q_f_value   <= nzcv_value;
    q_f_tag     <= nzcv_tag;
    bc_tag      <= fu_tag;
    bc_value    <= fu_value;
    bc_set_nzcv <= fu_set_nzcv;
    bc_nzcv     <= fu_nzcv;
  end

  always_comb begin
    rs_insert_valid = q_valid;
    rs_op           = q_op;
    rs_set_nzcv     = q_set_nzcv;
    rs_dst_tag      = q_tag;
    rs_a_tag        = q_a_tag;
    rs_b_tag        = q_b_tag;
    rs_f_tag        = q_f_tag;
    rs_a_ready = q_a_ready || ent_done[q_a_tag] || (bc_valid && bc_tag == q_a_tag);
    rs_a_value = q_a_ready ? q_a_value : (ent_done[q_a_tag] ? ent_value[q_a_tag] : bc_value);
    rs_b_ready = q_b_ready || ent_done[q_b_tag] || (bc_valid && bc_tag == q_b_tag);
    rs_b_value = q_b_ready ? q_b_value : (ent_done[q_b_tag] ? ent_value[q_b_tag] : bc_value);
    rs_f_ready = q_f_ready || ent_done[q_f_tag] ||
                 (bc_valid && bc_set_nzcv && bc_tag == q_f_tag);
    rs_f_value = q_f_ready ? q_f_value : (ent_done[q_f_tag] ? ent_nzcv[q_f_tag] : bc_nzcv);
    // Head entry retires as soon as its result is in
    commit_valid    = ent_done[head];
    commit_tag      = head;
    commit_dst      = ent_dst[head];
    commit_value    = ent_value[head];
    commit_set_nzcv = ent_set_nzcv[head];
    commit_nzcv     = ent_nzcv[head];
  end

endmodule

`default_nettype wire

/* hw/rename_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_regfile #(
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic                           in_clk,
  input  logic                           in_rst_n,
  input  logic                           issue_valid,
  input  logic [ooo_pkg::OP_W-1:0]       issue_op,
  input  logic [ooo_pkg::GPR_IDX_W-1:0]  issue_dst,
  input  logic [ooo_pkg::GPR_IDX_W-1:0]  issue_src1,
  input  logic [ooo_pkg::GPR_IDX_W-1:0]  issue_src2,
  input  logic                           issue_set_nzcv,
  input  logic                           rob_full,
  input  logic                           rs_full,
  input  logic [TAG_W-1:0]               alloc_tag,
  input  logic                           commit_valid,
  input  logic [TAG_W-1:0]               commit_tag,
  input  logic [ooo_pkg::GPR_IDX_W-1:0]  commit_dst,
  input  logic [ooo_pkg::GPR_W-1:0]      commit_value,
  input  logic                           commit_set_nzcv,
  input  logic [ooo_pkg::NZCV_W-1:0]     commit_nzcv,
  output logic                           issue_ready,
  output logic                           alloc_valid,
  output logic [ooo_pkg::OP_W-1:0]       alloc_op,
  output logic [ooo_pkg::GPR_IDX_W-1:0]  alloc_dst,
  output logic                           alloc_set_nzcv,
  output logic                           src1_ready,
  output logic [ooo_pkg::GPR_W-1:0]      src1_value,
  output logic [TAG_W-1:0]               src1_tag,
  output logic                           src2_ready,
  output logic [ooo_pkg::GPR_W-1:0]      src2_value,
  output logic [TAG_W-1:0]               src2_tag,
  output logic                           nzcv_ready,
  output logic [ooo_pkg::NZCV_W-1:0]     nzcv_value,
  output logic [TAG_W-1:0]               nzcv_tag
);
  import ooo_pkg::*;

  logic [GPR_W-1:0]     regs    [GPR_COUNT];
  logic [TAG_W-1:0]     reg_tag [GPR_COUNT];
  logic [GPR_COUNT-1:0] reg_busy;  // Register waits on a ROB entry
  logic [NZCV_W-1:0]    flags;
  logic [TAG_W-1:0]     flags_tag;
  logic                 flags_busy;
  logic                 accept;

  assign issue_ready    = !rob_full && !rs_full;
  assign accept         = issue_valid && issue_ready;
  assign alloc_valid    = accept;
  assign alloc_op       = issue_op;
  assign alloc_dst      = issue_dst;
  assign alloc_set_nzcv = issue_set_nzcv;

  // Operand read, a busy source whose producer commits now takes the commit value
  always_comb begin
    src1_tag   = reg_tag[issue_src1];
    src1_ready = !reg_busy[issue_src1] || (commit_valid && commit_tag == src1_tag);
    src1_value = reg_busy[issue_src1] ? commit_value : regs[issue_src1];
    src2_tag   = reg_tag[issue_src2];
    src2_ready = !reg_busy[issue_src2] || (commit_valid && commit_tag == src2_tag);
    src2_value = reg_busy[issue_src2] ? commit_value : regs[issue_src2];
    nzcv_tag   = flags_tag;
    nzcv_ready = !flags_busy || (commit_valid && commit_tag == flags_tag);
    nzcv_value = flags_busy ? commit_nzcv : flags;
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      for (int i = 0; i < GPR_COUNT; i++) begin
        regs[i]    <= '0;
        reg_tag[i] <= '0;
      end
      reg_busy   <= '0;
      flags      <= '0;
      flags_tag  <= '0;
      flags_busy <= 1'b0;
    end else begin
      if (commit_valid) begin
        regs[commit_dst] <= commit_value;
        // Only the newest producer releases the register
        if (reg_tag[commit_dst] == commit_tag && !(accept && issue_dst == commit_dst))
          reg_busy[commit_dst] <= 1'b0;
        if (commit_set_nzcv) begin
          flags <= commit_nzcv;
          if (flags_tag == commit_tag && !(accept && issue_set_nzcv))
            flags_busy <= 1'b0;
        end
      end
      if (accept) begin
        reg_busy[issue_dst] <= 1'b1;
        reg_tag[issue_dst]  <= alloc_tag;
        if (issue_set_nzcv) begin
          flags_busy <= 1'b1;  // Flags renamed like a register
          flags_tag  <= alloc_tag;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

  // Datapath widths
  localparam int GPR_W     = 32;
  localparam int GPR_COUNT = 16;
  localparam int GPR_IDX_W = 4;
  localparam int NZCV_W    = 4;

  // Flag positions inside a flag word
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  localparam int OP_W = 3;

  localparam logic [OP_W-1:0] OP_MOV = 3'd0;  // Passes source 2
  localparam logic [OP_W-1:0] OP_ADD = 3'd1;
  localparam logic [OP_W-1:0] OP_SUB = 3'd2;
  localparam logic [OP_W-1:0] OP_AND = 3'd3;
  localparam logic [OP_W-1:0] OP_ORR = 3'd4;
  localparam logic [OP_W-1:0] OP_EOR = 3'd5;
  localparam logic [OP_W-1:0] OP_ADC = 3'd6;  // Adds the carry flag

endpackage

`default_nettype wire
